// File: design/noc_pkg.sv
// ======================================
// Tile index wraps at 2**TILE_W, so NUM_TILES is a power of two
// FIFO_DEPTH is a power of two and also the longest packet
// ======================================
`default_nettype none

package noc_pkg;

   // Network size
   localparam int NUM_TILES  = 4;
   localparam int TILE_W     = 2;

   // Payload width of one flit
   localparam int DATA_W     = 32;

   // Ingress buffer depth, link credits and longest packet
   localparam int FIFO_DEPTH = 4;

   // Holds 0 to FIFO_DEPTH
   localparam int CREDIT_W   = 3;

   // Position of a flit inside its packet
   typedef enum logic [1:0] {
      FLIT_HEAD,
      FLIT_BODY,
      FLIT_LAST,
      // One-flit packet, head and last at once
      FLIT_SINGLE
   } flit_type_e;

   // Per switch output
   typedef enum logic {
      ARB_IDLE,
      ARB_LOCKED
   } arb_state_e;

   // One flit, 38 bits
   typedef struct packed {
      flit_type_e          ftype;
      // Set by the tile in every flit of a packet
      logic [TILE_W-1:0]   dest;
      // Stamped by the ingress
      logic [TILE_W-1:0]   src;
      logic [DATA_W-1:0]   data;
   } flit_t;

endpackage

`default_nettype wire

// File: design/na_ingress.sv
// ======================================
// No overflow check; the tile must keep to its credits
// ======================================
`default_nettype none
`timescale 1ns/1ps

module na_ingress
   import noc_pkg::*;
#(
   parameter int TILE_ID = 0
) (
   input  wire   clk_i,
   input  wire   arst_n_i,

   // From the tile
   input  flit_t tile_flit_i,
   input  wire   tile_valid_i,
   output logic  tile_credit_o,

   // Toward the switch
   output flit_t req_flit_o,
   output logic  req_valid_o,
   input  wire   pop_i
);

   // Circular buffer storage
   flit_t mem_q [FIFO_DEPTH];

   // Pointers wrap on their own, depth is a power of two
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;

   // Occupancy, 0 to FIFO_DEPTH
   logic [CREDIT_W-1:0] count_q;

   // Incoming flit with this tile as source
   flit_t wr_flit;

   always_comb begin
      wr_flit     = tile_flit_i;
      wr_flit.src = TILE_W'(TILE_ID);
   end

   // Payload store
   always_ff @(posedge clk_i) begin
      if (tile_valid_i) begin
         mem_q[wr_ptr_q] <= wr_flit;
      end
   end

   // Pointer, occupancy and credit return
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q      <= '0;
         rd_ptr_q      <= '0;
         count_q       <= '0;
         tile_credit_o <= 1'b0;
      end else begin
         if (tile_valid_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Write and pop may share a cycle
         count_q <= count_q + CREDIT_W'(tile_valid_i) - CREDIT_W'(pop_i);
         // One credit per freed entry, a cycle after the pop
         tile_credit_o <= pop_i;
      end
   end

   // Oldest flit is the request
   assign req_valid_o = (count_q != '0);
   assign req_flit_o  = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: design/noc_switch.sv
// ======================================
// Pop is combinational in the grant cycle; flit and valid are registered
// An input's flit targets a single output, so at most one output pops it
// ======================================
`default_nettype none
`timescale 1ns/1ps

module noc_switch
   import noc_pkg::*;
(
   input  wire                   clk_i,
   input  wire                   arst_n_i,

   // From the ingresses
   input  flit_t                 req_flit_i  [NUM_TILES],
   input  wire   [NUM_TILES-1:0] req_valid_i,
   output logic  [NUM_TILES-1:0] pop_o,

   // Toward the egresses
   output flit_t                 sw_flit_o   [NUM_TILES],
   output logic  [NUM_TILES-1:0] sw_valid_o,
   input  wire   [NUM_TILES-1:0] sw_ready_i
);

   // Per output arbitration state
   arb_state_e        state_q [NUM_TILES];
   logic [TILE_W-1:0] owner_q [NUM_TILES];
   logic [TILE_W-1:0] rr_q    [NUM_TILES];

   // Selected input and forward strobe per output
   logic [TILE_W-1:0]    sel [NUM_TILES];
   logic [NUM_TILES-1:0] fwd;

   // Grant search
   always_comb begin
      logic              found;
      logic [TILE_W-1:0] idx;
      for (int o = 0; o < NUM_TILES; o++) begin
         found  = 1'b0;
         idx    = '0;
         sel[o] = owner_q[o];
         fwd[o] = 1'b0;
         if (state_q[o] == ARB_LOCKED) begin
            // Only the owner moves, and only with downstream room
            fwd[o] = req_valid_i[owner_q[o]] && sw_ready_i[o];
         end else begin
            // Round robin from the pointer
            for (int k = 0; k < NUM_TILES; k++) begin
               idx = rr_q[o] + TILE_W'(k);
               if (!found && req_valid_i[idx] &&
                   req_flit_i[idx].dest == TILE_W'(o) &&
                   (req_flit_i[idx].ftype == FLIT_HEAD ||
                    req_flit_i[idx].ftype == FLIT_SINGLE)) begin
                  found  = 1'b1;
                  sel[o] = idx;
               end
            end
            // Head goes out in the grant cycle
            fwd[o] = found && sw_ready_i[o];
         end
      end
   end

   // Acknowledge to the selected inputs
   always_comb begin
      pop_o = '0;
      for (int o = 0; o < NUM_TILES; o++) begin
         if (fwd[o]) begin
            pop_o[sel[o]] = 1'b1;
         end
      end
   end

   // Lock, release and pointer update
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sw_valid_o <= '0;
         for (int o = 0; o < NUM_TILES; o++) begin
            state_q[o] <= ARB_IDLE;
            owner_q[o] <= '0;
            rr_q[o]    <= '0;
         end
      end else begin
         sw_valid_o <= fwd;
         for (int o = 0; o < NUM_TILES; o++) begin
            if (fwd[o]) begin
               case (req_flit_i[sel[o]].ftype)
                  FLIT_HEAD: begin
                     state_q[o] <= ARB_LOCKED;
                     owner_q[o] <= sel[o];
                  end
                  FLIT_LAST, FLIT_SINGLE: begin
                     // Next search starts past the owner
                     state_q[o] <= ARB_IDLE;
                     rr_q[o]    <= sel[o] + 1'b1;
                  end
                  default: begin
                     // Body flit keeps the lock
                     state_q[o] <= state_q[o];
                  end
               endcase
            end
         end
      end
   end

   // Crossbar data path
   always_ff @(posedge clk_i) begin
      for (int o = 0; o < NUM_TILES; o++) begin
         if (fwd[o]) begin
            sw_flit_o[o] <= req_flit_i[sel[o]];
         end
      end
   end

endmodule

`default_nettype wire

// File: design/na_egress.sv
// ======================================
// Output register holds each flit for one cycle; the tile must take it
// ======================================
`default_nettype none
`timescale 1ns/1ps

module na_egress
   import noc_pkg::*;
(
   input  wire   clk_i,
   input  wire   arst_n_i,

   // From the switch
   input  flit_t sw_flit_i,
   input  wire   sw_valid_i,
   output logic  sw_ready_o,

   // Toward the tile
   output flit_t out_flit_o,
   output logic  out_valid_o,
   input  wire   out_credit_i
);

   // Credits the tile has granted
   logic [CREDIT_W-1:0] credit_q;

   // Output register empties every cycle
   // The flit arriving now already owns one credit
   assign sw_ready_o = (credit_q > CREDIT_W'(sw_valid_i));

   // Credit count and valid
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credit_q    <= CREDIT_W'(FIFO_DEPTH);
         out_valid_o <= 1'b0;
      end else begin
         case ({sw_valid_i, out_credit_i})
            // Spent one
            2'b10:   credit_q <= credit_q - 1'b1;
            // Got one back
            2'b01:   credit_q <= credit_q + 1'b1;
            // Both or neither, no change
            default: credit_q <= credit_q;
         endcase
         out_valid_o <= sw_valid_i;
      end
   end

   // Flit register toward the tile
   always_ff @(posedge clk_i) begin
      if (sw_valid_i) begin
         out_flit_o <= sw_flit_i;
      end
   end

endmodule

`default_nettype wire

// File: design/system_2x2.sv
// ======================================
// Tiles sit outside; each link starts with FIFO_DEPTH credits
// ======================================
`default_nettype none
`timescale 1ns/1ps

module system_2x2
   import noc_pkg::*;
(
   input  wire                   clk_i,
   input  wire                   arst_n_i,

   // Tile to network
   input  flit_t                 tile_flit_i   [NUM_TILES],
   input  wire   [NUM_TILES-1:0] tile_valid_i,
   output logic  [NUM_TILES-1:0] tile_credit_o,

   // Network to tile
   output flit_t                 out_flit_o    [NUM_TILES],
   output logic  [NUM_TILES-1:0] out_valid_o,
   input  wire   [NUM_TILES-1:0] out_credit_i
);

   // Ingress to switch
   flit_t                req_flit [NUM_TILES];
   logic [NUM_TILES-1:0] req_valid;
   logic [NUM_TILES-1:0] pop;

   // Switch to egress
   flit_t                sw_flit  [NUM_TILES];
   logic [NUM_TILES-1:0] sw_valid;
   logic [NUM_TILES-1:0] sw_ready;

   for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile
      // Source stamp comes from the loop index
      na_ingress #(
         .TILE_ID (t)
      ) u_ingress (
         .clk_i         (clk_i),
         .arst_n_i      (arst_n_i),
         .tile_flit_i   (tile_flit_i[t]),
         .tile_valid_i  (tile_valid_i[t]),
         .tile_credit_o (tile_credit_o[t]),
         .req_flit_o    (req_flit[t]),
         .req_valid_o   (req_valid[t]),
         .pop_i         (pop[t])
      );

      na_egress u_egress (
         .clk_i        (clk_i),
         .arst_n_i     (arst_n_i),
         .sw_flit_i    (sw_flit[t]),
         .sw_valid_i   (sw_valid[t]),
         .sw_ready_o   (sw_ready[t]),
         .out_flit_o   (out_flit_o[t]),
         .out_valid_o  (out_valid_o[t]),
         .out_credit_i (out_credit_i[t])
      );
   end

   // Single crossbar between all tiles
   noc_switch u_switch (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_flit_i  (req_flit),
      .req_valid_i (req_valid),
      .pop_o       (pop),
      .sw_flit_o   (sw_flit),
      .sw_valid_o  (sw_valid),
      .sw_ready_i  (sw_ready)
   );

endmodule

`default_nettype wire

// File: tb/system_2x2_sva.sv
// ========================================
// Reaches into ingress and egress counters by hierarchical names
// ========================================
`default_nettype none
`timescale 1ns/1ps

module system_2x2_sva
   import noc_pkg::*;
(
   input wire                            clk_i,
   input wire                            arst_n_i,
   input wire   [NUM_TILES-1:0]          tile_valid_i,
   input wire   [NUM_TILES-1:0]          tile_credit_i,
   input wire   [NUM_TILES-1:0]          out_valid_i,
   input flit_t                          out_flit_i [NUM_TILES],
   input wire   [NUM_TILES-1:0]          sw_valid_i,
   input wire   [NUM_TILES*CREDIT_W-1:0] ing_count_i,
   input wire   [NUM_TILES*CREDIT_W-1:0] eg_credit_i
);

   for (genvar t = 0; t < NUM_TILES; t++) begin : gen_chk
      // Per tile slices of the counters
      wire [CREDIT_W-1:0] ing_count = ing_count_i[t*CREDIT_W +: CREDIT_W];
      wire [CREDIT_W-1:0] eg_credit = eg_credit_i[t*CREDIT_W +: CREDIT_W];
      wire                starts    = (out_flit_i[t].ftype == FLIT_HEAD) ||
                                      (out_flit_i[t].ftype == FLIT_SINGLE);
      // Packet open at this output and its source
      logic               in_pkt_q;
      logic [TILE_W-1:0]  owner_q;

      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            in_pkt_q <= 1'b0;
            owner_q  <= '0;
         end else if (out_valid_i[t]) begin
            in_pkt_q <= (out_flit_i[t].ftype == FLIT_HEAD) ||
                        (out_flit_i[t].ftype == FLIT_BODY && in_pkt_q);
            if (out_flit_i[t].ftype == FLIT_HEAD) begin
               owner_q <= out_flit_i[t].src;
            end
         end
      end

      // Quiet outputs in reset and on the first cycle after it
      assert property (@(posedge clk_i) (!arst_n_i || $rose(arst_n_i)) |->
                       (!out_valid_i[t] && !tile_credit_i[t]))
         else $error("tile %0d output active around reset", t);

      // No write into a full ingress buffer
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
                       tile_valid_i[t] |-> (ing_count != CREDIT_W'(FIFO_DEPTH)))
         else $error("ingress %0d written while full", t);

      // Egress credit counter stays in range and never spends from zero
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
                       (eg_credit <= CREDIT_W'(FIFO_DEPTH)) &&
                       (!sw_valid_i[t] || eg_credit != '0))
         else $error("egress %0d credit counter wrapped", t);

      // Head opens a packet, body and last continue it from the same source
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
                       out_valid_i[t] |-> (starts != in_pkt_q) &&
                       (!in_pkt_q || out_flit_i[t].src == owner_q))
         else $error("packets interleaved at output %0d", t);
   end

endmodule

bind system_2x2 system_2x2_sva sva_i (
   .clk_i         (clk_i),
   .arst_n_i      (arst_n_i),
   .tile_valid_i  (tile_valid_i),
   .tile_credit_i (tile_credit_o),
   .out_valid_i   (out_valid_o),
   .out_flit_i    (out_flit_o),
   .sw_valid_i    (sw_valid),
   .ing_count_i   ({gen_tile[3].u_ingress.count_q, gen_tile[2].u_ingress.count_q,
                    gen_tile[1].u_ingress.count_q, gen_tile[0].u_ingress.count_q}),
   .eg_credit_i   ({gen_tile[3].u_egress.credit_q, gen_tile[2].u_egress.credit_q,
                    gen_tile[1].u_egress.credit_q, gen_tile[0].u_egress.credit_q})
);

`default_nettype wire

// File: tb/tb_system_2x2.sv
// ========================================
// Tile models act on the falling edge; traffic from a fixed-seed LCG
// The last packets of every tile all go to tile 0
// ========================================
`default_nettype none
`timescale 1ns/1ps

module tb_system_2x2
   import noc_pkg::*;
#(
   parameter logic [31:0] SEED = 32'he8b72aa0
);

   // Packets per tile, 200 in all
   localparam int PKTS     = 50;
   // From this sequence number on, every packet targets tile 0
   localparam int HOT_SEQ  = 40;
   localparam int WATCHDOG = NUM_TILES * PKTS * FIFO_DEPTH * 40;

   logic                 clk;
   logic                 arst_n;
   flit_t                tile_flit [NUM_TILES];
   flit_t                out_flit  [NUM_TILES];
   logic [NUM_TILES-1:0] tile_valid;
   logic [NUM_TILES-1:0] tile_credit;
   logic [NUM_TILES-1:0] out_valid;
   logic [NUM_TILES-1:0] out_credit;

   logic [31:0]          rng;
   // Credits toward the ingress, credits granted to the egress, flits not yet credited
   int                   tx_cred [NUM_TILES];
   int                   rx_cred [NUM_TILES];
   int                   owed    [NUM_TILES];
   int                   stall   [NUM_TILES];
   // Sender packet state
   int                   len     [NUM_TILES];
   int                   left    [NUM_TILES];
   int                   seq     [NUM_TILES];
   logic [TILE_W-1:0]    dst     [NUM_TILES];
   // Receiver packet state
   logic                 in_pkt  [NUM_TILES];
   logic [TILE_W-1:0]    owner   [NUM_TILES];
   // Packets from other sources delivered ahead of a waiting head, per source
   int                   overtaken [NUM_TILES];
   // Scoreboard, one queue per source and destination
   flit_t                exp_q   [NUM_TILES*NUM_TILES][$];

   system_2x2 dut_i (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .tile_flit_i   (tile_flit),
      .tile_valid_i  (tile_valid),
      .tile_credit_o (tile_credit),
      .out_flit_o    (out_flit),
      .out_valid_o   (out_valid),
      .out_credit_i  (out_credit)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic int draw(int n);
      rng = rng * 32'd1664525 + 32'd1013904223;
      return int'(rng[30:8]) % n;
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
      abort_run($sformatf("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act));
   endtask

   // Send one flit if a credit is held, opening a new packet when needed
   task automatic drive_tile(int t);
      flit_t f;
      tile_valid[t] = 1'b0;
      if (tx_cred[t] == 0 || (left[t] == 0 && seq[t] == PKTS) || draw(4) == 0) begin
         return;
      end
      if (left[t] == 0) begin
         len[t]  = 1 + draw(FIFO_DEPTH);
         left[t] = len[t];
         dst[t]  = (seq[t] >= HOT_SEQ) ? '0 : TILE_W'(draw(NUM_TILES));
      end
      f.ftype = (len[t] == 1) ? FLIT_SINGLE : (left[t] == len[t]) ? FLIT_HEAD :
                (left[t] == 1) ? FLIT_LAST : FLIT_BODY;
      f.dest  = dst[t];
      // Junk source, the ingress must restamp it
      f.src   = TILE_W'(draw(NUM_TILES));
      f.data  = {8'(t), 16'(seq[t]), 8'(len[t] - left[t])};
      tile_flit[t]  = f;
      tile_valid[t] = 1'b1;
      tx_cred[t]--;
      f.src = TILE_W'(t);
      exp_q[t*NUM_TILES + int'(dst[t])].push_back(f);
      left[t]--;
      if (left[t] == 0) begin
         seq[t]++;
      end
   endtask

   // Oldest undelivered flit of source s is a head bound for tile d
   function automatic bit head_waiting(int s, int d);
      flit_t h;
      flit_t g;
      if (exp_q[s*NUM_TILES + d].size() == 0) begin
         return 1'b0;
      end
      h = exp_q[s*NUM_TILES + d][0];
      if (h.ftype != FLIT_HEAD && h.ftype != FLIT_SINGLE) begin
         return 1'b0;
      end
      // Older packet of the same source still on its way elsewhere
      for (int k = 0; k < NUM_TILES; k++) begin
         if (exp_q[s*NUM_TILES + k].size() != 0) begin
            g = exp_q[s*NUM_TILES + k][0];
            if (g.data[23:8] < h.data[23:8]) begin
               return 1'b0;
            end
         end
      end
      return 1'b1;
   endfunction

   // Sample outputs, score arrivals, then decide on a credit return
   task automatic take_output(int t);
      flit_t f;
      int    key;
      if (tile_credit[t]) begin
         tx_cred[t]++;
         assert (tx_cred[t] <= FIFO_DEPTH)
            else abort_run($sformatf("Tile %0d got back more credits than it has", t));
      end
      if (out_valid[t]) begin
         f   = out_flit[t];
         key = int'(f.src) * NUM_TILES + t;
         assert (rx_cred[t] > 0)
            else abort_run($sformatf("Tile %0d got a flit while holding no credit", t));
         rx_cred[t]--;
         owed[t]++;
         assert (exp_q[key].size() > 0)
            else abort_run($sformatf("Tile %0d got a flit nobody sent", t));
         assert (f == exp_q[key][0])
            else report_mismatch($sformatf("out_flit_o[%0d]", t), 64'(exp_q[key][0]), 64'(f));
         void'(exp_q[key].pop_front());
         assert (!in_pkt[t] || f.src == owner[t])
            else report_mismatch($sformatf("out_flit_o[%0d].src", t), 64'(owner[t]), 64'(f.src));
         assert ((f.ftype == FLIT_HEAD || f.ftype == FLIT_SINGLE) != in_pkt[t])
            else abort_run($sformatf("Flit types out of packet order at tile %0d", t));
         in_pkt[t] = (f.ftype == FLIT_HEAD) || (f.ftype == FLIT_BODY && in_pkt[t]);
         if (f.ftype == FLIT_HEAD || f.ftype == FLIT_SINGLE) begin
            owner[t]          = f.src;
            overtaken[f.src]  = 0;
         end
         // Round robin lets only a few packets pass a waiting head
         if (!in_pkt[t]) begin
            for (int s = 0; s < NUM_TILES; s++) begin
               if (s != int'(f.src) && head_waiting(s, t)) begin
                  overtaken[s]++;
                  assert (overtaken[s] <= 2 * NUM_TILES)
                     else abort_run($sformatf("Tile %0d starved at output %0d", s, t));
               end
            end
         end
      end
      // Random stalls hold credits back and build back-pressure
      out_credit[t] = 1'b0;
      if (stall[t] > 0) begin
         stall[t]--;
      end else if (draw(16) == 0) begin
         stall[t] = draw(24);
      end else if (owed[t] > 0) begin
         out_credit[t] = 1'b1;
         owed[t]--;
         rx_cred[t]++;
      end
   endtask

   // All packets sent and delivered, all credits home
   function automatic bit drained();
      for (int t = 0; t < NUM_TILES; t++) begin
         if (seq[t] != PKTS || tx_cred[t] != FIFO_DEPTH || rx_cred[t] != FIFO_DEPTH) begin
            return 1'b0;
         end
      end
      for (int k = 0; k < NUM_TILES*NUM_TILES; k++) begin
         if (exp_q[k].size() != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      abort_run("Timeout, traffic did not drain in time");
   end

   initial begin
      rng        = SEED;
      arst_n     = 1'b0;
      tile_valid = '0;
      out_credit = '0;
      for (int t = 0; t < NUM_TILES; t++) begin
         tile_flit[t] = '0;
         tx_cred[t]   = FIFO_DEPTH;
         rx_cred[t]   = FIFO_DEPTH;
         owed[t]      = 0;
         stall[t]     = 0;
         len[t]       = 0;
         left[t]      = 0;
         seq[t]       = 0;
         dst[t]       = '0;
         in_pkt[t]    = 1'b0;
         owner[t]     = '0;
         overtaken[t] = 0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      while (!drained()) begin
         @(negedge clk);
         for (int t = 0; t < NUM_TILES; t++) begin
            take_output(t);
            drive_tile(t);
         end
      end
      // Let the last credit pulse reach the egress
      @(negedge clk);
      out_credit = '0;
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
design/noc_pkg.sv
design/na_ingress.sv
design/noc_switch.sv
design/na_egress.sv
design/system_2x2.sv
tb/system_2x2_sva.sv
tb/tb_system_2x2.sv

// File: Makefile
# Verilator flow for the 2x2 tile interconnect
VERILATOR ?= verilator
TOP       ?= tb_system_2x2
FLIST     ?= vlog.f
SEED      ?= e8b72aa0
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# The simulator exits nonzero on any $fatal or failed assertion
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=32\'h$(SEED) \
		-f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
